// File: hw/exec_config.svh
////////////////////
// Width and depth settings for the integer execute cluster
// Pulled in by the package and by every unit that sizes on them
////////////////////

`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Operand and result width
`define EXEC_XLEN 32

// Tag attached by issue, one per outstanding operation
`define EXEC_TAG_W 4

// Multiplier pipeline depth, at least 1
`define EXEC_MUL_STAGES 2

`endif

// File: hw/exec_pkg.sv
////////////////////
// Shared types of the execute cluster
// Imported by every RTL module of the cluster
////////////////////

`default_nettype none

package exec_pkg;

`include "exec_config.svh"

    // One code selects both the unit and the operation
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        XOR    = 4'd2,
        OR     = 4'd3,
        AND    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        MUL    = 4'd8,
        MULH   = 4'd9,
        MULHSU = 4'd10,
        MULHU  = 4'd11,
        DIV    = 4'd12,
        DIVU   = 4'd13,
        REM    = 4'd14,
        REMU   = 4'd15
    } exec_func_e;

    // Issue request, 72 bits
    typedef struct packed {
        exec_func_e              func;
        logic [`EXEC_XLEN-1:0]   a;
        logic [`EXEC_XLEN-1:0]   b;
        logic [`EXEC_TAG_W-1:0]  tag;
    } exec_req_t;

    // Unit and cluster response, 36 bits
    typedef struct packed {
        logic [`EXEC_XLEN-1:0]   result;
        logic [`EXEC_TAG_W-1:0]  tag;
    } exec_rsp_t;

    // Execution unit classes
    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_DIV = 2'd2
    } exec_unit_e;

endpackage

`default_nettype wire

// File: hw/alu.sv
////////////////////
// Single-cycle ALU with a one-entry output buffer
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module alu import exec_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      req_valid_i,
    input  exec_req_t req_i,
    output logic      req_ready_o,
    output logic      rsp_valid_o,
    output exec_rsp_t rsp_o,
    input  logic      rsp_ready_i
);

    localparam int XLEN = `EXEC_XLEN;
    localparam int SHW  = $clog2(XLEN);

    function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] v);
        logic [XLEN-1:0] r;
        for (int i = 0; i < XLEN; i++) begin
            r[XLEN-1-i] = v[i];
        end
        return r;
    endfunction

    logic                   is_sub;
    logic [XLEN-1:0]        b_op;
    logic [XLEN-1:0]        sum;
    logic signed [XLEN:0]   shift_in;
    logic [XLEN:0]          shift_out;
    logic [XLEN-1:0]        result;
    logic                   rsp_valid_q;
    exec_rsp_t              rsp_q;

    ////////////////////
    // Datapath
    ////////////////////

    // Subtract as a plus inverted b plus one
    assign is_sub = (req_i.func == SUB);
    assign b_op   = is_sub ? ~req_i.b : req_i.b;
    assign sum    = req_i.a + b_op + {{(XLEN-1){1'b0}}, is_sub};

    // Universal shifter, left shifts run reversed through the right shifter
    always_comb begin
        case (req_i.func)
            SRA:     shift_in = {req_i.a[XLEN-1], req_i.a};
            SRL:     shift_in = {1'b0, req_i.a};
            default: shift_in = {1'b0, bit_rev(req_i.a)};
        endcase
    end

    assign shift_out = shift_in >>> req_i.b[SHW-1:0];

    always_comb begin
        case (req_i.func)
            XOR:      result = req_i.a ^ req_i.b;
            OR:       result = req_i.a | req_i.b;
            AND:      result = req_i.a & req_i.b;
            SLL:      result = bit_rev(shift_out[XLEN-1:0]);
            SRL, SRA: result = shift_out[XLEN-1:0];
            default:  result = sum;
        endcase
    end

    ////////////////////
    // Output buffer
    ////////////////////

    // Accept when empty or draining this cycle
    assign req_ready_o = !rsp_valid_q || rsp_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (req_ready_o) begin
            rsp_valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            rsp_q.result <= result;
            rsp_q.tag    <= req_i.tag;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// File: hw/mul_unit.sv
////////////////////
// Pipelined 33x33 signed multiplier for the M extension products
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module mul_unit import exec_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      req_valid_i,
    input  exec_req_t req_i,
    output logic      req_ready_o,
    output logic      rsp_valid_o,
    output exec_rsp_t rsp_o,
    input  logic      rsp_ready_i
);

    localparam int XLEN   = `EXEC_XLEN;
    localparam int STAGES = `EXEC_MUL_STAGES;

    typedef struct packed {
        logic [2*XLEN-1:0]      prod;
        logic                   hi;
        logic [`EXEC_TAG_W-1:0] tag;
    } mul_stage_t;

    logic                     a_signed;
    logic                     b_signed;
    logic signed [XLEN:0]     a_ext;
    logic signed [XLEN:0]     b_ext;
    logic signed [2*XLEN+1:0] prod_full;
    logic                     advance;
    logic [STAGES-1:0]        valid_q;
    mul_stage_t               stage_in;
    mul_stage_t               stage_q [STAGES];

    // Only MULHU treats a as unsigned, only MUL and MULH treat b as signed
    assign a_signed = (req_i.func != MULHU);
    assign b_signed = (req_i.func == MUL) || (req_i.func == MULH);
    assign a_ext    = {a_signed & req_i.a[XLEN-1], req_i.a};
    assign b_ext    = {b_signed & req_i.b[XLEN-1], req_i.b};

    // Full product enters the pipe, the stages leave room for retiming
    assign prod_full     = a_ext * b_ext;
    assign stage_in.prod = prod_full[2*XLEN-1:0];
    assign stage_in.hi   = (req_i.func != MUL);
    assign stage_in.tag  = req_i.tag;

    // Whole pipe stalls while the last stage is held
    assign advance     = !valid_q[STAGES-1] || rsp_ready_i;
    assign req_ready_o = advance;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q <= (valid_q << 1) | STAGES'(req_valid_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance) begin
            stage_q[0] <= stage_in;
            for (int k = 1; k < STAGES; k++) begin
                stage_q[k] <= stage_q[k-1];
            end
        end
    end

    assign rsp_valid_o  = valid_q[STAGES-1];
    assign rsp_o.result = stage_q[STAGES-1].hi ? stage_q[STAGES-1].prod[2*XLEN-1:XLEN]
                                               : stage_q[STAGES-1].prod[XLEN-1:0];
    assign rsp_o.tag    = stage_q[STAGES-1].tag;

endmodule

`default_nettype wire

// File: hw/div_unit.sv
////////////////////
// Iterative restoring divider, one operation at a time, 33 cycles
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module div_unit import exec_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      req_valid_i,
    input  exec_req_t req_i,
    output logic      req_ready_o,
    output logic      rsp_valid_o,
    output exec_rsp_t rsp_o,
    input  logic      rsp_ready_i
);

    localparam int XLEN = `EXEC_XLEN;
    localparam int CW   = $clog2(XLEN);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    div_state_e             state_q;
    logic [CW-1:0]          cnt_q;
    logic                   is_signed;
    logic                   a_neg;
    logic                   b_neg;
    logic                   start;
    logic [XLEN-1:0]        quo_q;
    logic [XLEN-1:0]        rem_q;
    logic [XLEN-1:0]        dvs_q;
    logic                   neg_q_q;
    logic                   neg_r_q;
    logic                   dz_q;
    logic                   ovf_q;
    logic                   rem_sel_q;
    logic [`EXEC_TAG_W-1:0] tag_q;
    logic [XLEN+1:0]        trial;
    logic [XLEN-1:0]        quo_fix;
    logic [XLEN-1:0]        rem_fix;

    assign is_signed   = (req_i.func == DIV) || (req_i.func == REM);
    assign a_neg       = is_signed & req_i.a[XLEN-1];
    assign b_neg       = is_signed & req_i.b[XLEN-1];
    assign req_ready_o = (state_q == DIV_IDLE);
    assign start       = req_valid_i && req_ready_o;

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: if (start) begin
                    state_q <= DIV_RUN;
                    cnt_q   <= '0;
                end
                DIV_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CW'(XLEN - 1)) begin
                        state_q <= DIV_DONE;
                    end
                end
                DIV_DONE: if (rsp_ready_i) begin
                    state_q <= DIV_IDLE;
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    ////////////////////
    // Datapath
    ////////////////////

    // Shift in the next dividend bit and try to subtract the divisor
    assign trial = {1'b0, rem_q, quo_q[XLEN-1]} - {2'b00, dvs_q};

    always_ff @(posedge clk_i) begin
        if (start) begin
            // Setup takes magnitudes and records the sign fix-up
            quo_q     <= a_neg ? (~req_i.a + 1'b1) : req_i.a;
            dvs_q     <= b_neg ? (~req_i.b + 1'b1) : req_i.b;
            rem_q     <= '0;
            neg_q_q   <= a_neg ^ b_neg;
            neg_r_q   <= a_neg;
            dz_q      <= (req_i.b == '0);
            ovf_q     <= is_signed && (req_i.a == {1'b1, {(XLEN-1){1'b0}}}) && (req_i.b == '1);
            rem_sel_q <= (req_i.func == REM) || (req_i.func == REMU);
            tag_q     <= req_i.tag;
        end else if (state_q == DIV_RUN) begin
            quo_q <= {quo_q[XLEN-2:0], !trial[XLEN+1]};
            rem_q <= trial[XLEN+1] ? {rem_q[XLEN-2:0], quo_q[XLEN-1]} : trial[XLEN-1:0];
        end
    end

    assign quo_fix = neg_q_q ? (~quo_q + 1'b1) : quo_q;
    assign rem_fix = neg_r_q ? (~rem_q + 1'b1) : rem_q;

    // A zero divisor leaves the dividend in the remainder after sign restore
    always_comb begin
        if (ovf_q) begin
            rsp_o.result = rem_sel_q ? '0 : {1'b1, {(XLEN-1){1'b0}}};
        end else if (dz_q) begin
            rsp_o.result = rem_sel_q ? rem_fix : '1;
        end else begin
            rsp_o.result = rem_sel_q ? rem_fix : quo_fix;
        end
    end

    assign rsp_o.tag   = tag_q;
    assign rsp_valid_o = (state_q == DIV_DONE);

endmodule

`default_nettype wire

// File: hw/issue_router.sv
////////////////////
// Steers one issue request to the ALU, multiplier or divider
////////////////////

`timescale 1ns/1ps
`default_nettype none

module issue_router import exec_pkg::*; (
    input  logic      req_valid_i,
    input  exec_req_t req_i,
    output logic      req_ready_o,
    output logic      alu_valid_o,
    output logic      mul_valid_o,
    output logic      div_valid_o,
    output exec_req_t unit_req_o,
    input  logic      alu_ready_i,
    input  logic      mul_ready_i,
    input  logic      div_ready_i
);

    exec_unit_e unit_sel;

    // Class from the function code
    always_comb begin
        case (req_i.func)
            MUL, MULH, MULHSU, MULHU: unit_sel = UNIT_MUL;
            DIV, DIVU, REM, REMU:     unit_sel = UNIT_DIV;
            default:                  unit_sel = UNIT_ALU;
        endcase
    end

    assign alu_valid_o = req_valid_i && (unit_sel == UNIT_ALU);
    assign mul_valid_o = req_valid_i && (unit_sel == UNIT_MUL);
    assign div_valid_o = req_valid_i && (unit_sel == UNIT_DIV);

    // Only the selected unit's ready goes back to issue
    always_comb begin
        case (unit_sel)
            UNIT_MUL: req_ready_o = mul_ready_i;
            UNIT_DIV: req_ready_o = div_ready_i;
            default:  req_ready_o = alu_ready_i;
        endcase
    end

    // Payload goes to all units
    assign unit_req_o = req_i;

endmodule

`default_nettype wire

// File: hw/result_arbiter.sv
////////////////////
// Round-robin merge of the three unit responses onto one result port
////////////////////

`timescale 1ns/1ps
`default_nettype none

module result_arbiter import exec_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      alu_valid_i,
    input  logic      mul_valid_i,
    input  logic      div_valid_i,
    input  exec_rsp_t alu_rsp_i,
    input  exec_rsp_t mul_rsp_i,
    input  exec_rsp_t div_rsp_i,
    output logic      alu_ready_o,
    output logic      mul_ready_o,
    output logic      div_ready_o,
    output logic      rsp_valid_o,
    output exec_rsp_t rsp_o,
    input  logic      rsp_ready_i
);

    localparam int N_UNITS = 3;

    logic [N_UNITS-1:0] valid_vec;
    exec_unit_e         prio_q;
    exec_unit_e         gnt_unit;
    logic               gnt_found;
    logic               xfer;

    assign valid_vec = {div_valid_i, mul_valid_i, alu_valid_i};

    // Search starts at the pointer and wraps around
    always_comb begin
        int idx;
        gnt_found = 1'b0;
        gnt_unit  = prio_q;
        for (int k = 0; k < N_UNITS; k++) begin
            idx = (int'(prio_q) + k) % N_UNITS;
            if (!gnt_found && valid_vec[idx]) begin
                gnt_found = 1'b1;
                gnt_unit  = exec_unit_e'(idx[1:0]);
            end
        end
    end

    assign xfer        = gnt_found && rsp_ready_i;
    assign rsp_valid_o = gnt_found;
    assign alu_ready_o = xfer && (gnt_unit == UNIT_ALU);
    assign mul_ready_o = xfer && (gnt_unit == UNIT_MUL);
    assign div_ready_o = xfer && (gnt_unit == UNIT_DIV);

    always_comb begin
        case (gnt_unit)
            UNIT_MUL: rsp_o = mul_rsp_i;
            UNIT_DIV: rsp_o = div_rsp_i;
            default:  rsp_o = alu_rsp_i;
        endcase
    end

    // Granted unit drops to lowest priority
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            prio_q <= UNIT_ALU;
        end else if (xfer) begin
            case (gnt_unit)
                UNIT_ALU: prio_q <= UNIT_MUL;
                UNIT_MUL: prio_q <= UNIT_DIV;
                default:  prio_q <= UNIT_ALU;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/exec_cluster.sv
////////////////////
// Integer execute cluster top, router to three units to result arbiter
////////////////////

`timescale 1ns/1ps
`default_nettype none

module exec_cluster import exec_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      req_valid_i,
    input  exec_req_t req_i,
    output logic      req_ready_o,
    output logic      rsp_valid_o,
    output exec_rsp_t rsp_o,
    input  logic      rsp_ready_i
);

    exec_req_t unit_req;
    logic      alu_req_valid, mul_req_valid, div_req_valid;
    logic      alu_req_ready, mul_req_ready, div_req_ready;
    logic      alu_rsp_valid, mul_rsp_valid, div_rsp_valid;
    logic      alu_rsp_ready, mul_rsp_ready, div_rsp_ready;
    exec_rsp_t alu_rsp, mul_rsp, div_rsp;

    issue_router u_router (
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .alu_valid_o (alu_req_valid),
        .mul_valid_o (mul_req_valid),
        .div_valid_o (div_req_valid),
        .unit_req_o  (unit_req),
        .alu_ready_i (alu_req_ready),
        .mul_ready_i (mul_req_ready),
        .div_ready_i (div_req_ready)
    );

    ////////////////////
    // Execution units
    ////////////////////

    alu u_alu (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (alu_req_valid),
        .req_i       (unit_req),
        .req_ready_o (alu_req_ready),
        .rsp_valid_o (alu_rsp_valid),
        .rsp_o       (alu_rsp),
        .rsp_ready_i (alu_rsp_ready)
    );

    mul_unit u_mul (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (mul_req_valid),
        .req_i       (unit_req),
        .req_ready_o (mul_req_ready),
        .rsp_valid_o (mul_rsp_valid),
        .rsp_o       (mul_rsp),
        .rsp_ready_i (mul_rsp_ready)
    );

    div_unit u_div (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (div_req_valid),
        .req_i       (unit_req),
        .req_ready_o (div_req_ready),
        .rsp_valid_o (div_rsp_valid),
        .rsp_o       (div_rsp),
        .rsp_ready_i (div_rsp_ready)
    );

    result_arbiter u_arb (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .alu_valid_i (alu_rsp_valid),
        .mul_valid_i (mul_rsp_valid),
        .div_valid_i (div_rsp_valid),
        .alu_rsp_i   (alu_rsp),
        .mul_rsp_i   (mul_rsp),
        .div_rsp_i   (div_rsp),
        .alu_ready_o (alu_rsp_ready),
        .mul_ready_o (mul_rsp_ready),
        .div_ready_o (div_rsp_ready),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i)
    );

endmodule

`default_nettype wire

// File: dv/exec_ref_model.svh
////////////////////
// Expected results for every function code, from the RV32IM rules
// Included inside the testbench module, after the package import
////////////////////

`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// Add, sub, logic ops and shifts by the low five bits of b
function automatic logic [`EXEC_XLEN-1:0] alu_model(
    input exec_func_e            func,
    input logic [`EXEC_XLEN-1:0] a,
    input logic [`EXEC_XLEN-1:0] b
);
    int sh;
    sh = b % `EXEC_XLEN;
    case (func)
        SUB:     return a - b;
        XOR:     return a ^ b;
        OR:      return a | b;
        AND:     return a & b;
        SLL:     return a << sh;
        SRL:     return a >> sh;
        SRA:     return $signed(a) >>> sh;
        default: return a + b;
    endcase
endfunction

// Full 64-bit product, operands extended by the signedness of each function
function automatic logic [`EXEC_XLEN-1:0] product_model(
    input exec_func_e            func,
    input logic [`EXEC_XLEN-1:0] a,
    input logic [`EXEC_XLEN-1:0] b
);
    logic [2*`EXEC_XLEN-1:0] ax;
    logic [2*`EXEC_XLEN-1:0] bx;
    logic [2*`EXEC_XLEN-1:0] p;
    ax = {{`EXEC_XLEN{1'b0}}, a};
    bx = {{`EXEC_XLEN{1'b0}}, b};
    if (func != MULHU) begin
        ax = {{`EXEC_XLEN{a[`EXEC_XLEN-1]}}, a};
    end
    if (func == MUL || func == MULH) begin
        bx = {{`EXEC_XLEN{b[`EXEC_XLEN-1]}}, b};
    end
    p = ax * bx;
    return (func == MUL) ? p[`EXEC_XLEN-1:0] : p[2*`EXEC_XLEN-1:`EXEC_XLEN];
endfunction

// Quotient truncates toward zero, remainder takes the dividend's sign
function automatic logic [`EXEC_XLEN-1:0] divide_model(
    input exec_func_e            func,
    input logic [`EXEC_XLEN-1:0] a,
    input logic [`EXEC_XLEN-1:0] b
);
    logic signed [`EXEC_XLEN-1:0] sa;
    logic signed [`EXEC_XLEN-1:0] sb;
    logic [`EXEC_XLEN-1:0]        min_neg;
    logic                         zero_div;
    logic                         overflow;
    sa       = a;
    sb       = b;
    min_neg  = {1'b1, {(`EXEC_XLEN-1){1'b0}}};
    zero_div = (b == '0);
    overflow = (a == min_neg) && (b == '1);
    case (func)
        DIV: begin
            if (zero_div) begin
                return '1;
            end else if (overflow) begin
                return min_neg;
            end else begin
                return sa / sb;
            end
        end
        REM: begin
            if (zero_div) begin
                return a;
            end else if (overflow) begin
                return '0;
            end else begin
                return sa % sb;
            end
        end
        DIVU: return zero_div ? '1 : a / b;
        default: return zero_div ? a : a % b;
    endcase
endfunction

function automatic logic [`EXEC_XLEN-1:0] expected_result(
    input exec_func_e            func,
    input logic [`EXEC_XLEN-1:0] a,
    input logic [`EXEC_XLEN-1:0] b
);
    case (func)
        MUL, MULH, MULHSU, MULHU: return product_model(func, a, b);
        DIV, DIVU, REM, REMU:     return divide_model(func, a, b);
        default:                  return alu_model(func, a, b);
    endcase
endfunction

`endif

// File: dv/exec_tb.sv
////////////////////
// Random-stimulus testbench for the execute cluster
// Issues tagged operations and scoreboards the responses by tag
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module exec_tb import exec_pkg::*; ();

    localparam int          XLEN         = `EXEC_XLEN;
    localparam int          TAG_W        = `EXEC_TAG_W;
    localparam int          NTAGS        = 1 << TAG_W;
    localparam logic [31:0] SEED         = 32'h8bd6017a;
    localparam int          ACCEPT_LIMIT = 400;
    localparam int          TAG_LIMIT    = 400;
    localparam int          DRAIN_LIMIT  = 4000;
    localparam int          STALL_CYCLES = 60;
    localparam int          RDY_ALWAYS   = 0;
    localparam int          RDY_RANDOM   = 1;
    localparam int          RDY_HOLD     = 2;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    exec_req_t  req;
    logic       req_ready;
    logic       rsp_valid;
    exec_rsp_t  rsp;
    logic       rsp_ready;

    // Scoreboard, one entry per tag
    logic [NTAGS-1:0] busy;
    logic [XLEN-1:0]  expected [NTAGS];
    exec_func_e       issued_func [NTAGS];
    int               outstanding;
    int               rdy_mode;
    int               result_errs;
    int               flag_errs;
    int               tag_errs;

    `include "exec_ref_model.svh"

    exec_cluster dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_valid_i (req_valid),
        .req_i       (req),
        .req_ready_o (req_ready),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .rsp_ready_i (rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Result port back-pressure, changed on the falling edge
    initial begin
        rsp_ready = 1'b1;
        forever begin
            @(negedge clk);
            case (rdy_mode)
                RDY_RANDOM: rsp_ready = 1'($urandom % 2);
                RDY_HOLD:   rsp_ready = 1'b0;
                default:    rsp_ready = 1'b1;
            endcase
        end
    end

    always @(posedge clk) begin
        if (rst_n && rsp_valid && rsp_ready) begin
            check_rsp(rsp);
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    task automatic check_rsp(input exec_rsp_t got);
        int t;
        t = got.tag;
        if (!busy[t]) begin
            tag_errs++;
            $display("ERROR at %0t: a response came back with tag %0d, which was not issued",
                     $time, t);
        end else begin
            if (got.result !== expected[t]) begin
                result_errs++;
                $display("CHECK FAILED t=%0t rsp_o.result tag %0d (%s) expected %h actual %h",
                         $time, t, issued_func[t].name(), expected[t], got.result);
            end
            busy[t] = 1'b0;
            outstanding--;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errs++;
            $display("CHECK FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic print_counts();
        $display("Error counts: results=%0d flags=%0d tags=%0d", result_errs, flag_errs, tag_errs);
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        print_counts();
        $display("Checks failed");
        $finish;
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    function automatic int free_tag();
        int start;
        int idx;
        start = $urandom % NTAGS;
        for (int k = 0; k < NTAGS; k++) begin
            idx = (start + k) % NTAGS;
            if (!busy[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    function automatic logic [XLEN-1:0] rand_operand();
        case ($urandom % 8)
            0:       return '0;
            1:       return 1;
            2:       return '1;
            3:       return {1'b1, {(XLEN-1){1'b0}}};
            4:       return {1'b0, {(XLEN-1){1'b1}}};
            default: return $urandom;
        endcase
    endfunction

    // Presents one request on the falling edge, once a tag is free
    task automatic drive_req(input exec_func_e f, input logic [XLEN-1:0] a,
                             input logic [XLEN-1:0] b);
        int tag;
        int waited;
        waited = 0;
        @(negedge clk);
        tag = free_tag();
        while (tag < 0) begin
            req_valid = 1'b0;
            waited++;
            if (waited > TAG_LIMIT) begin
                abort_run("no tag became free before the timeout");
            end
            @(negedge clk);
            tag = free_tag();
        end
        busy[tag]        = 1'b1;
        expected[tag]    = expected_result(f, a, b);
        issued_func[tag] = f;
        outstanding++;
        req.func  = f;
        req.a     = a;
        req.b     = b;
        req.tag   = tag[TAG_W-1:0];
        req_valid = 1'b1;
    endtask

    task automatic wait_accept(input int limit, output logic ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < limit) begin
            @(posedge clk);
            ok = req_ready;
            cycles++;
        end
    endtask

    task automatic issue_op(input exec_func_e f, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        logic ok;
        drive_req(f, a, b);
        wait_accept(ACCEPT_LIMIT, ok);
        if (!ok) begin
            abort_run("a request was not accepted before the timeout");
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // Stops issuing and waits until every tag has come back
    task automatic finish_batch();
        int cycles;
        idle_cycle();
        cycles = 0;
        while (outstanding != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                abort_run("responses did not drain before the timeout");
            end
        end
        // Nothing may follow once every tag is back
        @(negedge clk);
        check_bit("rsp_valid_o", 1'b0, rsp_valid);
    endtask

    task automatic exercise_alu();
        exec_func_e f;
        // Shift amounts 0 and 31, upper bits of b must be ignored
        for (int k = 5; k <= 7; k++) begin
            f = exec_func_e'(4'(k));
            issue_op(f, 32'h8000_0001, 32'hffff_ffe0);
            issue_op(f, 32'h8000_0001, 32'h0000_001f);
            issue_op(f, $urandom, ($urandom & 32'hffff_ffe0) | 32'd31);
        end
        for (int n = 0; n < 200; n++) begin
            f = exec_func_e'(4'($urandom % 8));
            issue_op(f, rand_operand(), rand_operand());
        end
        finish_batch();
    endtask

    task automatic multiply_sweep();
        logic [XLEN-1:0] extremes [2];
        exec_func_e      f;
        extremes[0] = 32'h8000_0000;
        extremes[1] = 32'hffff_ffff;
        for (int k = 8; k <= 11; k++) begin
            for (int i = 0; i < 2; i++) begin
                for (int j = 0; j < 2; j++) begin
                    issue_op(exec_func_e'(4'(k)), extremes[i], extremes[j]);
                end
            end
        end
        for (int n = 0; n < 100; n++) begin
            f = exec_func_e'(4'(8 + $urandom % 4));
            issue_op(f, rand_operand(), rand_operand());
        end
        finish_batch();
    endtask

    task automatic divide_sweep();
        exec_func_e f;
        // Zero divisor and signed overflow for every divide function
        for (int k = 12; k <= 15; k++) begin
            f = exec_func_e'(4'(k));
            issue_op(f, rand_operand(), '0);
            issue_op(f, 32'h8000_0000, 32'hffff_ffff);
            issue_op(f, $urandom, 32'd7);
        end
        for (int n = 0; n < 60; n++) begin
            f = exec_func_e'(4'(12 + $urandom % 4));
            issue_op(f, rand_operand(), ($urandom % 2) ? $urandom % 16 : rand_operand());
        end
        finish_batch();
    endtask

    task automatic mixed_traffic();
        rdy_mode = RDY_RANDOM;
        for (int n = 0; n < 400; n++) begin
            if ($urandom % 4 == 0) begin
                idle_cycle();
            end
            issue_op(exec_func_e'(4'($urandom % 16)), rand_operand(), rand_operand());
        end
        finish_batch();
        rdy_mode = RDY_ALWAYS;
    endtask

    // Result port held shut until issue is blocked, then reopened
    task automatic backpressure_stall();
        logic ok;
        int   n;
        rdy_mode = RDY_HOLD;
        ok       = 1'b1;
        n        = 0;
        while (ok && n < NTAGS) begin
            drive_req(exec_func_e'(4'($urandom % 16)), rand_operand(), rand_operand());
            wait_accept(STALL_CYCLES, ok);
            n++;
        end
        check_bit("req_ready_o", 1'b0, req_ready);
        rdy_mode = RDY_ALWAYS;
        if (!ok) begin
            wait_accept(ACCEPT_LIMIT, ok);
            if (!ok) begin
                abort_run("the held request was not accepted after the result port opened");
            end
        end
        finish_batch();
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        rdy_mode    = RDY_ALWAYS;
        busy        = '0;
        outstanding = 0;
        result_errs = 0;
        flag_errs   = 0;
        tag_errs    = 0;
        repeat (11) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("rsp_valid_o", 1'b0, rsp_valid);
        check_bit("req_ready_o", 1'b1, req_ready);

        exercise_alu();
        multiply_sweep();
        divide_sweep();
        mixed_traffic();
        backpressure_stall();

        @(negedge clk);
        check_bit("rsp_valid_o", 1'b0, rsp_valid);
        print_counts();
        if (result_errs + flag_errs + tag_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hw
+incdir+dv
hw/exec_pkg.sv
hw/alu.sv
hw/mul_unit.sv
hw/div_unit.sv
hw/issue_router.sv
hw/result_arbiter.sv
hw/exec_cluster.sv
dv/exec_tb.sv

// File: Makefile
# Verilator build and run of the execute cluster testbench

VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := hw/exec_config.svh dv/exec_ref_model.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
